// ==== Bender.yml ====
package:
  name: sum_kernel

sources:
  - sum_kernel_pkg.sv
  - sync_fifo.sv
  - edge_accumulator.sv
  - sum_kernel_control.sv
  - result_writer.sv
  - sum_kernel_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_sum_kernel.sv

// ==== all.f ====
sum_kernel_pkg.sv
sync_fifo.sv
edge_accumulator.sv
sum_kernel_control.sv
result_writer.sv
sum_kernel_top.sv
tb_clock_gen.sv
tb_sum_kernel.sv

// ==== edge_accumulator.sv ====
`timescale 1ns/1ns

module edge_accumulator (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        clear,
	input  logic                        add,
	input  sum_kernel_pkg::edge_value_t edge_value,
	output sum_kernel_pkg::edge_value_t sum,
	output sum_kernel_pkg::degree_t     vertex_edges,
	output sum_kernel_pkg::count_t      edge_count
);

	sum_kernel_pkg::edge_value_t sum_next;
	sum_kernel_pkg::degree_t     vertex_edges_next;
	sum_kernel_pkg::count_t      edge_count_next;

	////////////////////////////////////////////////////////////////////////////
	// next values
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		sum_next          = sum;
		vertex_edges_next = vertex_edges;
		edge_count_next   = edge_count;

		// clear starts a new vertex
		if (clear) begin
			sum_next          = '0;
			vertex_edges_next = '0;
		end else if (add) begin
			// unsigned add, wraps modulo 2**32
			sum_next          = sum + edge_value;
			vertex_edges_next = vertex_edges + 1'b1;
		end

		// total edges never cleared except by reset
		if (add) begin
			edge_count_next = edge_count + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum          <= '0;
			vertex_edges <= '0;
		end else begin
			sum          <= sum_next;
			vertex_edges <= vertex_edges_next;
		end
	end

	// statistics
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_count <= '0;
		end else begin
			edge_count <= edge_count_next;
		end
	end

endmodule

// ==== result_writer.sv ====
`timescale 1ns/1ns

module result_writer (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enable,
	input  sum_kernel_pkg::bus_address_t result_base,

	// result queue head
	input  sum_kernel_pkg::result_word_t result_head,
	input  logic                         result_empty,
	output logic                         result_pop,

	// wishbone classic master
	output logic                         wb_cyc,
	output logic                         wb_stb,
	output logic                         wb_we,
	output sum_kernel_pkg::bus_address_t wb_adr,
	output sum_kernel_pkg::edge_value_t  wb_wdata,
	output logic [3:0]                   wb_sel,
	input  logic                         wb_ack,

	output sum_kernel_pkg::count_t       vertex_count
);

	typedef enum logic {
		WR_IDLE,
		WR_BUSY
	} writer_state_t;

	writer_state_t state;

	sum_kernel_pkg::vertex_id_t  head_id;
	sum_kernel_pkg::edge_value_t head_sum;
	logic                        start;

	// split the head entry
	assign head_id  = result_head[$bits(sum_kernel_pkg::result_word_t)-1 -:
		$bits(sum_kernel_pkg::vertex_id_t)];
	assign head_sum = result_head[$bits(sum_kernel_pkg::edge_value_t)-1:0];

	// new cycle only from idle, so cyc drops at least one clock between writes
	assign start      = (state == WR_IDLE) && enable && !result_empty;
	assign result_pop = (state == WR_BUSY) && wb_ack;

	// bus strobes follow the state register
	assign wb_cyc = (state == WR_BUSY);
	assign wb_stb = (state == WR_BUSY);
	assign wb_we  = (state == WR_BUSY);
	assign wb_sel = 4'hf;

	////////////////////////////////////////////////////////////////////////////
	// idle / busy
	////////////////////////////////////////////////////////////////////////////

	// an open cycle always finishes on ack, enable or not
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= WR_IDLE;
			vertex_count <= '0;
		end else begin
			if (start) begin
				state <= WR_BUSY;
			end else if (result_pop) begin
				state        <= WR_IDLE;
				vertex_count <= vertex_count + 1'b1;
			end
		end
	end

	// address and data held steady until ack
	always_ff @(posedge clock) begin
		if (start) begin
			// base plus four bytes per vertex
			wb_adr   <= result_base + {head_id, 2'b00};
			wb_wdata <= head_sum;
		end
	end

endmodule

// ==== sum_kernel_control.sv ====
`timescale 1ns/1ns

module sum_kernel_control (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enable,

	// job queue head
	input  sum_kernel_pkg::job_word_t    job_head,
	input  logic                         job_empty,
	output logic                         job_pop,

	// edge stream
	input  logic                         edge_valid,
	output logic                         edge_ready,

	// accumulator
	input  sum_kernel_pkg::degree_t      vertex_edges,
	input  sum_kernel_pkg::edge_value_t  sum,
	output logic                         acc_clear,
	output logic                         acc_add,

	// result queue tail
	input  logic                         result_full,
	output logic                         result_push,
	output sum_kernel_pkg::result_word_t result_data
);

	sum_kernel_pkg::control_state_t state;
	sum_kernel_pkg::control_state_t state_next;

	// current job, latched on pop
	sum_kernel_pkg::vertex_id_t vertex_id_q;
	sum_kernel_pkg::degree_t    degree_q;

	sum_kernel_pkg::degree_t    edges_after_add;
	logic                       last_edge;

	////////////////////////////////////////////////////////////////////////////
	// edge stream gating
	////////////////////////////////////////////////////////////////////////////

	// only take edges while accumulating and enabled
	assign edge_ready = enable && (state == sum_kernel_pkg::ACCUM);
	assign acc_add    = edge_valid && edge_ready;

	// count this vertex will reach if the current edge goes in
	assign edges_after_add = vertex_edges + 1'b1;
	assign last_edge       = (edges_after_add == degree_q);

	// id above the final sum
	assign result_data = {vertex_id_q, sum};

	////////////////////////////////////////////////////////////////////////////
	// fsm
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next  = state;
		job_pop     = 1'b0;
		acc_clear   = 1'b0;
		result_push = 1'b0;

		// enable low holds every state
		if (enable) begin
			case (state)
				sum_kernel_pkg::IDLE: begin
					if (!job_empty) begin
						job_pop    = 1'b1;
						acc_clear  = 1'b1;
						state_next = sum_kernel_pkg::LOAD;
					end
				end
				sum_kernel_pkg::LOAD: begin
					// zero degree skips straight to flush with sum 0
					if (degree_q == '0) begin
						state_next = sum_kernel_pkg::FLUSH;
					end else begin
						state_next = sum_kernel_pkg::ACCUM;
					end
				end
				sum_kernel_pkg::ACCUM: begin
					if (acc_add && last_edge) begin
						state_next = sum_kernel_pkg::FLUSH;
					end
				end
				sum_kernel_pkg::FLUSH: begin
					// wait here while the writer is backed up
					if (!result_full) begin
						result_push = 1'b1;
						state_next  = sum_kernel_pkg::IDLE;
					end
				end
				default: state_next = sum_kernel_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= sum_kernel_pkg::IDLE;
		end else begin
			state <= state_next;
		end
	end

	// job fields, taken straight off the queue head
	always_ff @(posedge clock) begin
		if (job_pop) begin
			vertex_id_q <= job_head[$bits(sum_kernel_pkg::job_word_t)-1 -:
				$bits(sum_kernel_pkg::vertex_id_t)];
			degree_q    <= job_head[$bits(sum_kernel_pkg::degree_t)-1:0];
		end
	end

endmodule

// ==== sum_kernel_pkg.sv ====
package sum_kernel_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	// vertex identifier as given by the host
	typedef logic [15:0] vertex_id_t;

	// number of edges belonging to one vertex
	typedef logic [15:0] degree_t;

	// one edge value, also used for the running sum
	typedef logic [31:0] edge_value_t;

	// wishbone byte address
	typedef logic [31:0] bus_address_t;

	// statistics counters
	typedef logic [31:0] count_t;

	// job queue entry, id in the upper half and degree in the lower half
	typedef logic [31:0] job_word_t;

	// result queue entry, vertex id sitting above the sum
	typedef logic [47:0] result_word_t;

	////////////////////////////////////////////////////////////////////////////
	// queue depths
	////////////////////////////////////////////////////////////////////////////

	localparam int JOB_QUEUE_DEPTH    = 4;
	localparam int RESULT_QUEUE_DEPTH = 4;

	////////////////////////////////////////////////////////////////////////////
	// control fsm
	////////////////////////////////////////////////////////////////////////////

	// idle waits for a job, load decides on zero degree,
	// accum takes edges, flush hands the sum to the writer
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		ACCUM,
		FLUSH
	} control_state_t;

endpackage

// ==== sum_kernel_top.sv ====
`timescale 1ns/1ns

module sum_kernel_top (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enable,
	input  sum_kernel_pkg::bus_address_t result_base,

	// host jobs
	input  logic                         job_valid,
	input  sum_kernel_pkg::vertex_id_t   job_id,
	input  sum_kernel_pkg::degree_t      job_degree,
	output logic                         job_ready,

	// host edges
	input  logic                         edge_valid,
	input  sum_kernel_pkg::edge_value_t  edge_value,
	output logic                         edge_ready,

	// wishbone master
	output logic                         wb_cyc,
	output logic                         wb_stb,
	output logic                         wb_we,
	output sum_kernel_pkg::bus_address_t wb_adr,
	output sum_kernel_pkg::edge_value_t  wb_wdata,
	output logic [3:0]                   wb_sel,
	input  logic                         wb_ack,

	// statistics
	output sum_kernel_pkg::count_t       edge_count,
	output sum_kernel_pkg::count_t       vertex_count
);

	sum_kernel_pkg::job_word_t    job_head;
	logic                         job_full;
	logic                         job_empty;
	logic                         job_pop;
	sum_kernel_pkg::result_word_t result_data;
	sum_kernel_pkg::result_word_t result_head;
	logic                         result_push;
	logic                         result_pop;
	logic                         result_full;
	logic                         result_empty;
	logic                         acc_clear;
	logic                         acc_add;
	sum_kernel_pkg::edge_value_t  sum;
	sum_kernel_pkg::degree_t      vertex_edges;

	// queue ignores pushes when full
	assign job_ready = !job_full;

	////////////////////////////////////////////////////////////////////////////
	// queues
	////////////////////////////////////////////////////////////////////////////

	sync_fifo #(
		.WIDTH($bits(sum_kernel_pkg::job_word_t)),
		.DEPTH(sum_kernel_pkg::JOB_QUEUE_DEPTH)
	) job_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_valid),
		.data_in ({job_id, job_degree}),
		.pop     (job_pop),
		.data_out(job_head),
		.full    (job_full),
		.empty   (job_empty)
	);

	sync_fifo #(
		.WIDTH($bits(sum_kernel_pkg::result_word_t)),
		.DEPTH(sum_kernel_pkg::RESULT_QUEUE_DEPTH)
	) result_queue (
		.clock   (clock),
		.rstn    (rstn),
		.push    (result_push),
		.data_in (result_data),
		.pop     (result_pop),
		.data_out(result_head),
		.full    (result_full),
		.empty   (result_empty)
	);

	////////////////////////////////////////////////////////////////////////////
	// datapath and control
	////////////////////////////////////////////////////////////////////////////

	edge_accumulator edge_accumulator (
		.clock       (clock),
		.rstn        (rstn),
		.clear       (acc_clear),
		.add         (acc_add),
		.edge_value  (edge_value),
		.sum         (sum),
		.vertex_edges(vertex_edges),
		.edge_count  (edge_count)
	);

	sum_kernel_control sum_kernel_control (
		.clock       (clock),
		.rstn        (rstn),
		.enable      (enable),
		.job_head    (job_head),
		.job_empty   (job_empty),
		.job_pop     (job_pop),
		.edge_valid  (edge_valid),
		.edge_ready  (edge_ready),
		.vertex_edges(vertex_edges),
		.sum         (sum),
		.acc_clear   (acc_clear),
		.acc_add     (acc_add),
		.result_full (result_full),
		.result_push (result_push),
		.result_data (result_data)
	);

	// drains the result queue onto the bus
	result_writer result_writer (
		.clock       (clock),
		.rstn        (rstn),
		.enable      (enable),
		.result_base (result_base),
		.result_head (result_head),
		.result_empty(result_empty),
		.result_pop  (result_pop),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_wdata    (wb_wdata),
		.wb_sel      (wb_sel),
		.wb_ack      (wb_ack),
		.vertex_count(vertex_count)
	);

endmodule

// ==== sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 4
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             empty
);

	// storage
	logic [WIDTH-1:0] mem [DEPTH];

	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       do_push;
	logic                       do_pop;

	// push when full and pop when empty are dropped here
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full  = (int'(count) == DEPTH);
	assign empty = (count == '0);

	// head always shown on the output
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// pointers wrap at depth even when not a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy only moves when exactly one side acts
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clock,
	output logic rstn
);

	// 40 ns period
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// reset held for 16 cycles, released on a falling edge
	initial begin
		rstn = 1'b0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
	end

endmodule

// ==== tb_sum_kernel.sv ====
`timescale 1ns/1ns

module tb_sum_kernel;

	// worst case over all tests with edges and vertices at their largest
	localparam int MAX_EDGES       = 5 + 8 * 12 + 2 * 12 + 6 * 12 + 3 * 12;
	localparam int MAX_VERTICES    = 1 + 8 + 3 + 6 + 3;
	localparam int MAX_ACK         = 20;
	localparam int PAUSE_CYCLES    = 40;
	localparam int WATCHDOG_CYCLES =
		2 * (16 + 2 * MAX_EDGES + MAX_VERTICES * (MAX_ACK + 8) + PAUSE_CYCLES);

	logic                         clock;
	logic                         rstn;
	logic                         enable;
	sum_kernel_pkg::bus_address_t result_base;
	logic                         job_valid;
	sum_kernel_pkg::vertex_id_t   job_id;
	sum_kernel_pkg::degree_t      job_degree;
	logic                         job_ready;
	logic                         edge_valid;
	sum_kernel_pkg::edge_value_t  edge_value;
	logic                         edge_ready;
	logic                         wb_cyc;
	logic                         wb_stb;
	logic                         wb_we;
	sum_kernel_pkg::bus_address_t wb_adr;
	sum_kernel_pkg::edge_value_t  wb_wdata;
	logic [3:0]                   wb_sel;
	logic                         wb_ack;
	sum_kernel_pkg::count_t       edge_count;
	sum_kernel_pkg::count_t       vertex_count;

	integer seed;
	int     error_count;
	int     tests_passed;
	int     tests_failed;
	int     ack_delay;
	int     ack_wait;
	bit     job_ready_low_seen;

	// running totals since reset
	sum_kernel_pkg::count_t sent_edges;
	sum_kernel_pkg::count_t sent_vertices;

	// pending stimulus
	sum_kernel_pkg::vertex_id_t   job_id_q[$];
	sum_kernel_pkg::degree_t      job_degree_q[$];
	sum_kernel_pkg::edge_value_t  edge_q[$];

	// reference results and slave writes in job order
	sum_kernel_pkg::bus_address_t exp_addr_q[$];
	sum_kernel_pkg::edge_value_t  exp_data_q[$];
	sum_kernel_pkg::bus_address_t write_addr_q[$];
	sum_kernel_pkg::edge_value_t  write_data_q[$];
	sum_kernel_pkg::edge_value_t  memory[sum_kernel_pkg::bus_address_t];

	// vertex being built
	sum_kernel_pkg::vertex_id_t   cur_id;
	sum_kernel_pkg::degree_t      cur_degree;
	sum_kernel_pkg::edge_value_t  cur_total;

	tb_clock_gen clock_gen (
		.clock(clock),
		.rstn (rstn)
	);

	sum_kernel_top dut (
		.clock       (clock),
		.rstn        (rstn),
		.enable      (enable),
		.result_base (result_base),
		.job_valid   (job_valid),
		.job_id      (job_id),
		.job_degree  (job_degree),
		.job_ready   (job_ready),
		.edge_valid  (edge_valid),
		.edge_value  (edge_value),
		.edge_ready  (edge_ready),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_wdata    (wb_wdata),
		.wb_sel      (wb_sel),
		.wb_ack      (wb_ack),
		.edge_count  (edge_count),
		.vertex_count(vertex_count)
	);

	////////////////////////////////////////////////////////////////////////////
	// wishbone slave memory
	////////////////////////////////////////////////////////////////////////////

	// one cycle ack pulse after ack_delay wait cycles
	always @(negedge clock) begin
		if (wb_ack) begin
			wb_ack = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (ack_wait >= ack_delay) begin
				if (wb_we !== 1'b1) begin
					$display("[FAIL] %0t wb_we expected 1 actual %b", $time, wb_we);
					error_count++;
				end
				if (wb_sel !== 4'hf) begin
					$display("[FAIL] %0t wb_sel expected f actual %h", $time, wb_sel);
					error_count++;
				end
				memory[wb_adr] = wb_wdata;
				write_addr_q.push_back(wb_adr);
				write_data_q.push_back(wb_wdata);
				ack_wait = 0;
				wb_ack = 1'b1;
			end else begin
				ack_wait++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input sum_kernel_pkg::edge_value_t expected,
		input sum_kernel_pkg::edge_value_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_address(input string name,
		input sum_kernel_pkg::bus_address_t expected, input sum_kernel_pkg::bus_address_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_count(input string name, input sum_kernel_pkg::count_t expected,
		input sum_kernel_pkg::count_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
			error_count++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model for jobs, edges and expected writes
	////////////////////////////////////////////////////////////////////////////

	task automatic start_vertex(input sum_kernel_pkg::vertex_id_t id);
		cur_id     = id;
		cur_degree = '0;
		cur_total  = '0;
	endtask

	task automatic add_edge(input sum_kernel_pkg::edge_value_t value);
		edge_q.push_back(value);
		// wraps modulo 2**32
		cur_total  = cur_total + value;
		cur_degree = cur_degree + 1'b1;
	endtask

	task automatic end_vertex();
		job_id_q.push_back(cur_id);
		job_degree_q.push_back(cur_degree);
		exp_addr_q.push_back(result_base + 32'd4 * sum_kernel_pkg::bus_address_t'(cur_id));
		exp_data_q.push_back(cur_total);
		sent_edges    = sent_edges + cur_degree;
		sent_vertices = sent_vertices + 1'b1;
	endtask

	task automatic add_random_vertex(input sum_kernel_pkg::vertex_id_t id, input int degree);
		start_vertex(id);
		repeat (degree) add_edge(sum_kernel_pkg::edge_value_t'($random(seed)));
		end_vertex();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// drivers entered and left on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_job(input sum_kernel_pkg::vertex_id_t id,
		input sum_kernel_pkg::degree_t degree);
		job_valid  = 1'b1;
		job_id     = id;
		job_degree = degree;
		// job_ready only moves on a rising edge
		while (!job_ready) begin
			job_ready_low_seen = 1'b1;
			@(negedge clock);
		end
		@(negedge clock);
		job_valid = 1'b0;
	endtask

	task automatic drive_edge(input sum_kernel_pkg::edge_value_t value);
		edge_valid = 1'b1;
		edge_value = value;
		while (!edge_ready) @(negedge clock);
		@(negedge clock);
		edge_valid = 1'b0;
	endtask

	// edge held on the stream while enable is low
	task automatic pause_stream(input sum_kernel_pkg::edge_value_t value);
		logic                   cyc_before;
		sum_kernel_pkg::count_t edges_before;
		edge_valid   = 1'b1;
		edge_value   = value;
		enable       = 1'b0;
		cyc_before   = wb_cyc;
		edges_before = edge_count;
		repeat (PAUSE_CYCLES) begin
			@(negedge clock);
			if (edge_ready) begin
				$display("%0t: edge_ready is high while enable is low", $time);
				error_count++;
			end
			if (wb_cyc && !cyc_before) begin
				$display("%0t: a bus cycle started while enable is low", $time);
				error_count++;
			end
			cyc_before = wb_cyc;
		end
		check_count("edge_count", edges_before, edge_count);
		// edge withdrawn for one cycle while edge_ready comes back
		edge_valid = 1'b0;
		enable     = 1'b1;
		@(negedge clock);
	endtask

	// jobs and edges run side by side
	// negative pause_after means no pause
	task automatic run_traffic(input int pause_after);
		fork
			begin
				while (job_id_q.size() > 0) begin
					drive_job(job_id_q.pop_front(), job_degree_q.pop_front());
				end
			end
			begin
				int sent;
				sent = 0;
				while (edge_q.size() > 0) begin
					if (sent == pause_after) begin
						pause_stream(edge_q[0]);
					end
					drive_edge(edge_q.pop_front());
					sent++;
				end
			end
		join
	endtask

	// waits until every expected write has been acked
	task automatic check_writes();
		int                           count;
		sum_kernel_pkg::bus_address_t addr;
		sum_kernel_pkg::edge_value_t  data;
		count = exp_addr_q.size();
		while (write_addr_q.size() < count) @(negedge clock);
		// room for a stray extra write
		repeat (ack_delay + 8) @(negedge clock);
		check_count("bus writes", count, write_addr_q.size());
		while (exp_addr_q.size() > 0 && write_addr_q.size() > 0) begin
			addr = exp_addr_q.pop_front();
			data = exp_data_q.pop_front();
			check_address("wb_adr", addr, write_addr_q.pop_front());
			check_value("wb_wdata", data, write_data_q.pop_front());
			if (!memory.exists(addr)) begin
				$display("%0t: nothing was written at address %h", $time, addr);
				error_count++;
			end else begin
				check_value("memory", data, memory[addr]);
			end
		end
		exp_addr_q.delete();
		exp_data_q.delete();
		write_addr_q.delete();
		write_data_q.delete();
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, error_count - errors_before);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic single_vertex_test();
		int errors_before;
		errors_before = error_count;
		ack_delay     = 0;
		result_base   = 32'h0001_0000;
		// last values wrap past 2**32
		start_vertex(16'd7);
		add_edge(32'd100);
		add_edge(32'h0000_1000);
		add_edge(32'd3);
		add_edge(32'hffff_fff0);
		add_edge(32'd45);
		end_vertex();
		run_traffic(-1);
		check_writes();
		finish_test("single vertex", errors_before);
	endtask

	task automatic random_vertices_test();
		int errors_before;
		errors_before = error_count;
		ack_delay     = 1;
		result_base   = 32'h0002_0400;
		for (int i = 0; i < 8; i++) begin
			add_random_vertex(16'd100 + 16'(i), 1 + ($unsigned($random(seed)) % 12));
		end
		run_traffic(-1);
		check_writes();
		finish_test("random vertices", errors_before);
	endtask

	task automatic zero_degree_test();
		int                     errors_before;
		sum_kernel_pkg::count_t edges_before;
		sum_kernel_pkg::count_t sent_before;
		errors_before = error_count;
		edges_before  = edge_count;
		sent_before   = sent_edges;
		ack_delay     = 2;
		result_base   = 32'h0003_0000;
		add_random_vertex(16'd200, 1 + ($unsigned($random(seed)) % 12));
		add_random_vertex(16'd201, 0);
		add_random_vertex(16'd202, 1 + ($unsigned($random(seed)) % 12));
		run_traffic(-1);
		check_writes();
		check_count("edge_count", edges_before + (sent_edges - sent_before), edge_count);
		finish_test("zero degree", errors_before);
	endtask

	task automatic back_pressure_test();
		int                     errors_before;
		sum_kernel_pkg::count_t edges_before;
		sum_kernel_pkg::count_t sent_before;
		errors_before      = error_count;
		edges_before       = edge_count;
		sent_before        = sent_edges;
		job_ready_low_seen = 1'b0;
		ack_delay          = MAX_ACK;
		result_base        = 32'h0004_0000;
		// at least four edges, so the first vertex outlasts the job pushes
		for (int i = 0; i < 6; i++) begin
			add_random_vertex(16'd300 + 16'(i), 4 + ($unsigned($random(seed)) % 9));
		end
		run_traffic(-1);
		check_writes();
		if (!job_ready_low_seen) begin
			$display("%0t: job_ready never went low under back-pressure", $time);
			error_count++;
		end
		check_count("edge_count", edges_before + (sent_edges - sent_before), edge_count);
		finish_test("back-pressure", errors_before);
	endtask

	task automatic enable_pause_test();
		int errors_before;
		errors_before = error_count;
		ack_delay     = MAX_ACK;
		result_base   = 32'h0005_0000;
		add_random_vertex(16'd400, 3);
		add_random_vertex(16'd401, 3);
		add_random_vertex(16'd402, 6);
		// pause in the middle of the third vertex
		run_traffic(8);
		check_writes();
		finish_test("enable pause", errors_before);
	endtask

	task automatic counter_test();
		int errors_before;
		errors_before = error_count;
		check_count("edge_count", sent_edges, edge_count);
		check_count("vertex_count", sent_vertices, vertex_count);
		finish_test("counters", errors_before);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		seed          = 29;
		error_count   = 0;
		tests_passed  = 0;
		tests_failed  = 0;
		ack_delay     = 0;
		ack_wait      = 0;
		sent_edges    = '0;
		sent_vertices = '0;
		enable        = 1'b0;
		result_base   = '0;
		job_valid     = 1'b0;
		job_id        = '0;
		job_degree    = '0;
		edge_valid    = 1'b0;
		edge_value    = '0;
		wb_ack        = 1'b0;
		@(posedge rstn);
		@(negedge clock);
		enable = 1'b1;
		single_vertex_test();
		random_vertices_test();
		zero_degree_test();
		back_pressure_test();
		enable_pause_test();
		counter_test();
		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && error_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout: tests still running after %0d clock cycles", WATCHDOG_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule
